/* source/sdram_pkg.sv */
package sdram_pkg;

	//////////////////////////////////////////////////
	// address and data types
	//////////////////////////////////////////////////

	localparam int BANK_W = 2;
	localparam int ROW_W  = 13;
	localparam int COL_W  = 9;

	// user address, 24 bits
	typedef struct packed {
		logic [BANK_W-1:0] bank;
		logic [ROW_W-1:0]  row;
		logic [COL_W-1:0]  col;
	} sdram_addr_t;

	typedef logic [15:0] data_t;

	//////////////////////////////////////////////////
	// command pins
	//////////////////////////////////////////////////

	typedef struct packed {
		logic cs_n;
		logic ras_n;
		logic cas_n;
		logic we_n;
	} sdram_cmd_t;

	localparam sdram_cmd_t CMD_NOP       = 4'b0111;
	localparam sdram_cmd_t CMD_ACTIVE    = 4'b0011;
	localparam sdram_cmd_t CMD_READ      = 4'b0101;
	localparam sdram_cmd_t CMD_WRITE     = 4'b0100;
	localparam sdram_cmd_t CMD_PRECHARGE = 4'b0010;
	localparam sdram_cmd_t CMD_REFRESH   = 4'b0001;
	localparam sdram_cmd_t CMD_MRS       = 4'b0000;

	//////////////////////////////////////////////////
	// state machines
	//////////////////////////////////////////////////

	typedef enum logic [3:0] {
		I_NOP, I_PRECHARGE, I_TRP, I_AUTO_REFRESH1, I_TRF1,
		I_AUTO_REFRESH2, I_TRF2, I_MRS, I_TMRD, I_DONE
	} init_state_t;

	typedef enum logic [3:0] {
		W_IDLE, W_ACTIVE, W_TRCD, W_READ, W_CL, W_RD,
		W_WRITE, W_WD, W_TDAL, W_AR, W_TRFC
	} work_state_t;

	// timing in clk_100m cycles
	localparam int T_RP      = 2;
	localparam int T_RFC     = 7;
	localparam int T_MRD     = 2;
	localparam int T_RCD     = 2;
	localparam int CAS_LAT   = 3;
	localparam int BURST_LEN = 4;
	localparam int T_DAL     = 4;

	// burst write, CL 3, sequential, BL 4
	localparam logic [12:0] MODE_WORD = 13'b000_0_00_011_0_010;

endpackage

/* source/sdram_ctrl.sv */
module sdram_ctrl import sdram_pkg::*; #(
	parameter int init_cycles      = 20000,
	parameter int refresh_interval = 748
) (
	input  logic        clk_100m,
	input  logic        rst_n,
	input  logic        wr_req,
	input  logic        rd_req,
	output init_state_t init_state,
	output work_state_t work_state,
	output logic [15:0] cnt_clk,
	output logic        load,
	output logic        rw_n,
	output logic        wr_ack,
	output logic        rd_ack,
	output logic        init_done,
	output logic        busy
);

	// command state counts as the first cycle of each spacing
	localparam logic [15:0] PWR_END  = 16'(init_cycles - 1);
	localparam logic [15:0] REF_END  = 16'(refresh_interval - 1);
	localparam logic [15:0] TRP_END  = 16'(T_RP - 2);
	localparam logic [15:0] TRFC_END = 16'(T_RFC - 2);
	localparam logic [15:0] TMRD_END = 16'(T_MRD - 2);
	localparam logic [15:0] TRCD_END = 16'(T_RCD - 2);
	localparam logic [15:0] CL_END   = 16'(CAS_LAT - 1);
	localparam logic [15:0] RD_END   = 16'(BURST_LEN);
	localparam logic [15:0] WD_END   = 16'(BURST_LEN - 2);
	localparam logic [15:0] TDAL_END = 16'(T_DAL - 1);

	init_state_t init_next;
	work_state_t work_next;
	logic [15:0] ref_cnt;
	logic        ref_req;

	assign init_done = (init_state == I_DONE);
	assign busy      = !(init_done && (work_state == W_IDLE));

	// refresh wins, otherwise any user request opens a row
	assign load = init_done && (work_state == W_IDLE) && !ref_req && (rd_req || wr_req);

	// rd_ack lines up with the last captured word in sdram_dq
	assign wr_ack = (work_state == W_TDAL) && (cnt_clk == '0);
	assign rd_ack = (work_state == W_RD) && (cnt_clk == RD_END);

	//////////////////////////////////////////////////
	// init sequence
	//////////////////////////////////////////////////

	always_comb begin
		init_next = init_state;
		case (init_state)
			I_NOP: begin
				if (cnt_clk == PWR_END)
					init_next = I_PRECHARGE;
			end
			I_PRECHARGE:     init_next = I_TRP;
			I_TRP: begin
				if (cnt_clk == TRP_END)
					init_next = I_AUTO_REFRESH1;
			end
			I_AUTO_REFRESH1: init_next = I_TRF1;
			I_TRF1: begin
				if (cnt_clk == TRFC_END)
					init_next = I_AUTO_REFRESH2;
			end
			I_AUTO_REFRESH2: init_next = I_TRF2;
			I_TRF2: begin
				if (cnt_clk == TRFC_END)
					init_next = I_MRS;
			end
			I_MRS:           init_next = I_TMRD;
			I_TMRD: begin
				if (cnt_clk == TMRD_END)
					init_next = I_DONE;
			end
			I_DONE:          init_next = I_DONE;
			default:         init_next = I_NOP;
		endcase
	end

	//////////////////////////////////////////////////
	// access and refresh
	//////////////////////////////////////////////////

	always_comb begin
		work_next = work_state;
		if (init_done) begin
			case (work_state)
				W_IDLE: begin
					if (ref_req)
						work_next = W_AR;
					else if (rd_req || wr_req)
						work_next = W_ACTIVE;
				end
				W_ACTIVE: work_next = W_TRCD;
				W_TRCD: begin
					if (cnt_clk == TRCD_END)
						work_next = rw_n ? W_WRITE : W_READ;
				end

				// read burst, auto-precharge
				W_READ:   work_next = W_CL;
				W_CL: begin
					if (cnt_clk == CL_END)
						work_next = W_RD;
				end
				W_RD: begin
					if (cnt_clk == RD_END)
						work_next = W_IDLE;
				end

				// write burst, auto-precharge
				W_WRITE:  work_next = W_WD;
				W_WD: begin
					if (cnt_clk == WD_END)
						work_next = W_TDAL;
				end
				W_TDAL: begin
					if (cnt_clk == TDAL_END)
						work_next = W_IDLE;
				end

				W_AR:     work_next = W_TRFC;
				W_TRFC: begin
					if (cnt_clk == TRFC_END)
						work_next = W_IDLE;
				end
				default:  work_next = W_IDLE;
			endcase
		end
	end

	// counter restarts on any state change
	always_ff @(posedge clk_100m or negedge rst_n) begin
		if (!rst_n) begin
			init_state <= I_NOP;
			work_state <= W_IDLE;
			cnt_clk    <= '0;
		end else begin
			init_state <= init_next;
			work_state <= work_next;
			if ((init_next != init_state) || (work_next != work_state))
				cnt_clk <= '0;
			else
				cnt_clk <= cnt_clk + 16'd1;
		end
	end

	// direction of the accepted request, read has priority
	always_ff @(posedge clk_100m or negedge rst_n) begin
		if (!rst_n)
			rw_n <= 1'b0;
		else if (load)
			rw_n <= !rd_req;
	end

	// refresh timer runs once init is done
	always_ff @(posedge clk_100m or negedge rst_n) begin
		if (!rst_n) begin
			ref_cnt <= '0;
			ref_req <= 1'b0;
		end else begin
			if (!init_done || (ref_cnt == REF_END))
				ref_cnt <= '0;
			else
				ref_cnt <= ref_cnt + 16'd1;

			if (init_done && (ref_cnt == REF_END))
				ref_req <= 1'b1;
			else if (work_state == W_AR)
				ref_req <= 1'b0;
		end
	end

endmodule

/* source/sdram_cmd.sv */
module sdram_cmd import sdram_pkg::*; (
	input  logic        clk_100m,
	input  logic        rst_n,
	input  init_state_t init_state,
	input  work_state_t work_state,
	input  logic        load,
	input  sdram_addr_t addr,
	output sdram_cmd_t  cmd,
	output logic [1:0]  ba,
	output logic [12:0] a,
	output logic [1:0]  dqm
);

	sdram_addr_t addr_q;
	sdram_cmd_t  cmd_d;
	logic [1:0]  ba_d;
	logic [12:0] a_d;

	always_ff @(posedge clk_100m) begin
		if (load)
			addr_q <= addr;
	end

	//////////////////////////////////////////////////
	// command decode
	//////////////////////////////////////////////////

	always_comb begin
		cmd_d = CMD_NOP;
		ba_d  = '0;
		a_d   = '0;
		if (init_state != I_DONE) begin
			case (init_state)
				I_PRECHARGE: begin
					// all banks
					cmd_d   = CMD_PRECHARGE;
					a_d[10] = 1'b1;
				end
				I_AUTO_REFRESH1, I_AUTO_REFRESH2: cmd_d = CMD_REFRESH;
				I_MRS: begin
					cmd_d = CMD_MRS;
					a_d   = MODE_WORD;
				end
				default: cmd_d = CMD_NOP;
			endcase
		end else begin
			case (work_state)
				W_ACTIVE: begin
					cmd_d = CMD_ACTIVE;
					ba_d  = addr_q.bank;
					a_d   = addr_q.row;
				end
				// a10 high selects auto-precharge
				W_READ: begin
					cmd_d = CMD_READ;
					ba_d  = addr_q.bank;
					a_d   = {2'b00, 1'b1, 1'b0, addr_q.col};
				end
				W_WRITE: begin
					cmd_d = CMD_WRITE;
					ba_d  = addr_q.bank;
					a_d   = {2'b00, 1'b1, 1'b0, addr_q.col};
				end
				W_AR:    cmd_d = CMD_REFRESH;
				default: cmd_d = CMD_NOP;
			endcase
		end
	end

	always_ff @(posedge clk_100m or negedge rst_n) begin
		if (!rst_n) begin
			cmd <= CMD_NOP;
			ba  <= '0;
			a   <= '0;
			dqm <= 2'b11;
		end else begin
			cmd <= cmd_d;
			ba  <= ba_d;
			a   <= a_d;
			dqm <= (init_state == I_DONE) ? 2'b00 : 2'b11;
		end
	end

endmodule

/* source/sdram_dq.sv */
module sdram_dq import sdram_pkg::*; (
	input  logic        clk_100m,
	input  logic        rst_n,
	input  work_state_t work_state,
	input  logic [15:0] cnt_clk,
	input  data_t       wr_data,
	input  data_t       dq_in,
	output data_t       dq_out,
	output logic        dq_oe,
	output logic        wr_data_next,
	output data_t       rd_data,
	output logic        rd_valid
);

	localparam int CNT_W = $clog2(BURST_LEN);

	logic             wr_burst;
	logic [CAS_LAT-1:0] rd_pipe;
	logic             rd_busy;
	logic [CNT_W-1:0] rd_cnt;

	//////////////////////////////////////////////////
	// write path
	//////////////////////////////////////////////////

	// one word per cycle from WRITE through the end of W_WD
	assign wr_burst = (work_state == W_WRITE) || (work_state == W_WD);

	// no request for a word after the last one
	assign wr_data_next = (work_state == W_WRITE) ||
		((work_state == W_WD) && (cnt_clk < 16'(BURST_LEN - 2)));

	always_ff @(posedge clk_100m) begin
		if (wr_burst)
			dq_out <= wr_data;
	end

	always_ff @(posedge clk_100m or negedge rst_n) begin
		if (!rst_n)
			dq_oe <= 1'b0;
		else
			dq_oe <= wr_burst;
	end

	//////////////////////////////////////////////////
	// read path
	//////////////////////////////////////////////////

	// cas latency delay, then a window of BURST_LEN samples
	always_ff @(posedge clk_100m or negedge rst_n) begin
		if (!rst_n) begin
			rd_pipe  <= '0;
			rd_busy  <= 1'b0;
			rd_cnt   <= '0;
			rd_valid <= 1'b0;
		end else begin
			rd_pipe  <= {rd_pipe[CAS_LAT-2:0], work_state == W_READ};
			rd_valid <= rd_busy;
			if (rd_pipe[CAS_LAT-1]) begin
				rd_busy <= 1'b1;
				rd_cnt  <= '0;
			end else if (rd_busy) begin
				rd_cnt <= rd_cnt + 1'b1;
				if (rd_cnt == CNT_W'(BURST_LEN - 1))
					rd_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_100m) begin
		if (rd_busy)
			rd_data <= dq_in;
	end

endmodule

/* source/sdram_top.sv */
module sdram_top import sdram_pkg::*; #(
	parameter int init_cycles      = 20000,
	parameter int refresh_interval = 748
) (
	input  logic        clk_100m,
	input  logic        rst_n,

	// user port
	input  logic        wr_req,
	input  logic        rd_req,
	input  sdram_addr_t addr,
	input  data_t       wr_data,
	output logic        wr_data_next,
	output logic        wr_ack,
	output logic        rd_ack,
	output data_t       rd_data,
	output logic        rd_valid,
	output logic        init_done,
	output logic        busy,

	// device pins
	output sdram_cmd_t  sdram_cmd,
	output logic [1:0]  sdram_ba,
	output logic [12:0] sdram_a,
	output logic [1:0]  sdram_dqm,
	inout  wire  [15:0] sdram_dq,
	output logic        sdram_cke
);

	init_state_t init_state;
	work_state_t work_state;
	logic [15:0] cnt_clk;
	logic        load;
	data_t       dq_out;
	logic        dq_oe;

	always_ff @(posedge clk_100m or negedge rst_n) begin
		if (!rst_n)
			sdram_cke <= 1'b0;
		else
			sdram_cke <= 1'b1;
	end

	assign sdram_dq = dq_oe ? dq_out : 'z;

	sdram_ctrl #(
		.init_cycles      (init_cycles),
		.refresh_interval (refresh_interval)
	) u_ctrl (
		.clk_100m   (clk_100m),
		.rst_n      (rst_n),
		.wr_req     (wr_req),
		.rd_req     (rd_req),
		.init_state (init_state),
		.work_state (work_state),
		.cnt_clk    (cnt_clk),
		.load       (load),
		.rw_n       (),
		.wr_ack     (wr_ack),
		.rd_ack     (rd_ack),
		.init_done  (init_done),
		.busy       (busy)
	);

	sdram_cmd u_cmd (
		.clk_100m   (clk_100m),
		.rst_n      (rst_n),
		.init_state (init_state),
		.work_state (work_state),
		.load       (load),
		.addr       (addr),
		.cmd        (sdram_cmd),
		.ba         (sdram_ba),
		.a          (sdram_a),
		.dqm        (sdram_dqm)
	);

	sdram_dq u_dq (
		.clk_100m     (clk_100m),
		.rst_n        (rst_n),
		.work_state   (work_state),
		.cnt_clk      (cnt_clk),
		.wr_data      (wr_data),
		.dq_in        (sdram_dq),
		.dq_out       (dq_out),
		.dq_oe        (dq_oe),
		.wr_data_next (wr_data_next),
		.rd_data      (rd_data),
		.rd_valid     (rd_valid)
	);

endmodule

/* sim/sdram_model.sv */
module sdram_model import sdram_pkg::*; (
	input  logic        clk_100m,
	input  sdram_cmd_t  cmd,
	input  logic [1:0]  ba,
	input  logic [12:0] a,
	input  logic        cke,
	inout  wire  [15:0] dq,
	output int          error_cnt
);

	timeunit 1ns;
	timeprecision 1ps;

	data_t       mem [logic [23:0]];
	logic [12:0] act_row [4];
	int          last_act [4];
	int          last_pre;
	int          last_ref;
	int          ncyc;
	int          rd_start;
	int          wr_start;
	logic [23:0] rd_base;
	logic [23:0] wr_base;
	logic        mrs_done;
	logic        drv_en;
	data_t       drv;

	assign dq = drv_en ? drv : 'z;

	// sequential burst of 4 wraps inside the aligned column group
	function automatic logic [23:0] burst_addr(input logic [23:0] base, input int i);
		return {base[23:2], 2'(base[1:0] + i)};
	endfunction

	initial begin
		error_cnt = 0;
		ncyc      = 0;
		last_pre  = -100;
		last_ref  = -100;
		rd_start  = -100;
		wr_start  = -100;
		mrs_done  = 1'b0;
		drv_en    = 1'b0;
		drv       = '0;
		for (int i = 0; i < 4; i++)
			last_act[i] = -100;
	end

	// pins are registered on the rising edge, sample them mid-cycle
	always @(negedge clk_100m) begin
		if (cke && (cmd != CMD_NOP)) begin
			if (ncyc - last_pre < T_RP) begin
				$display("model: command issued before precharge time elapsed");
				error_cnt++;
			end
			if (ncyc - last_ref < T_RFC) begin
				$display("model: command issued before refresh time elapsed");
				error_cnt++;
			end
			case (cmd)
				CMD_PRECHARGE: last_pre = ncyc;
				CMD_REFRESH:   last_ref = ncyc;
				CMD_MRS:       mrs_done = 1'b1;
				CMD_ACTIVE: begin
					if (!mrs_done) begin
						$display("model: row activated before mode register set");
						error_cnt++;
					end
					act_row[ba]  = a;
					last_act[ba] = ncyc;
				end
				CMD_READ, CMD_WRITE: begin
					if (!mrs_done) begin
						$display("model: access before mode register set");
						error_cnt++;
					end
					if (ncyc - last_act[ba] < T_RCD) begin
						$display("model: column command too soon after activate");
						error_cnt++;
					end
					if (cmd == CMD_READ) begin
						rd_start = ncyc + CAS_LAT;
						rd_base  = {ba, act_row[ba], a[8:0]};
					end else begin
						wr_start = ncyc;
						wr_base  = {ba, act_row[ba], a[8:0]};
					end
				end
				default: ;
			endcase
		end

		// write words arrive together with the WRITE command
		if ((ncyc >= wr_start) && (ncyc < wr_start + BURST_LEN))
			mem[burst_addr(wr_base, ncyc - wr_start)] = dq;

		if ((ncyc >= rd_start) && (ncyc < rd_start + BURST_LEN)) begin
			drv_en = 1'b1;
			if (mem.exists(burst_addr(rd_base, ncyc - rd_start)))
				drv = mem[burst_addr(rd_base, ncyc - rd_start)];
			else
				drv = '0;
		end else begin
			drv_en = 1'b0;
		end
		ncyc++;
	end

endmodule

/* sim/tb_sdram.sv */
module tb_sdram import sdram_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int INIT_CYCLES    = 50;
	localparam int REF_INTERVAL   = 120;
	localparam int N_RANDOM       = 40;
	localparam int LONGEST_ACCESS = 20;
	localparam int N_OPS          = N_RANDOM + 3;
	localparam int CYCLE_LIMIT    = 500 + 60 * N_OPS;

	logic        clk_100m;
	logic        rst_n;
	logic        wr_req;
	logic        rd_req;
	sdram_addr_t addr;
	data_t       wr_data;
	logic        wr_data_next;
	logic        wr_ack;
	logic        rd_ack;
	data_t       rd_data;
	logic        rd_valid;
	logic        init_done;
	logic        busy;
	sdram_cmd_t  pin_cmd;
	logic [1:0]  pin_ba;
	logic [12:0] pin_a;
	logic [1:0]  pin_dqm;
	wire  [15:0] pin_dq;
	logic        pin_cke;
	int          model_errors;

	// outputs as seen mid-cycle
	logic        s_wr_next;
	logic        s_wr_ack;
	logic        s_rd_ack;
	logic        s_rd_valid;
	logic        s_init_done;
	logic        s_busy;
	data_t       s_rd_data;

	int          cyc = 0;
	int          wr_ack_total = 0;
	int          rd_ack_total = 0;
	int          valid_total = 0;
	int          ack_mis = 0;
	int          dqm_viol = 0;
	int          ref_after_init = 0;
	int          init_viol = 0;
	int          busy_viol = 0;
	int          ref_win = 0;
	logic        in_access = 1'b0;
	sdram_cmd_t  init_cmds [$];
	logic [12:0] mrs_a = '0;
	logic [15:0] lfsr = 16'd8;
	data_t       ref_mem [logic [23:0]];
	int          test_err;
	int          tests_run = 0;
	int          tests_failed = 0;

	sdram_top #(
		.init_cycles      (INIT_CYCLES),
		.refresh_interval (REF_INTERVAL)
	) UUT (
		.clk_100m     (clk_100m),
		.rst_n        (rst_n),
		.wr_req       (wr_req),
		.rd_req       (rd_req),
		.addr         (addr),
		.wr_data      (wr_data),
		.wr_data_next (wr_data_next),
		.wr_ack       (wr_ack),
		.rd_ack       (rd_ack),
		.rd_data      (rd_data),
		.rd_valid     (rd_valid),
		.init_done    (init_done),
		.busy         (busy),
		.sdram_cmd    (pin_cmd),
		.sdram_ba     (pin_ba),
		.sdram_a      (pin_a),
		.sdram_dqm    (pin_dqm),
		.sdram_dq     (pin_dq),
		.sdram_cke    (pin_cke)
	);

	sdram_model mem_model (
		.clk_100m  (clk_100m),
		.cmd       (pin_cmd),
		.ba        (pin_ba),
		.a         (pin_a),
		.cke       (pin_cke),
		.dq        (pin_dq),
		.error_cnt (model_errors)
	);

	initial begin
		clk_100m = 1'b0;
		forever #5 clk_100m = ~clk_100m;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	// fibonacci lfsr x^16 + x^14 + x^13 + x^11, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [23:0] word_addr(input sdram_addr_t ad, input int i);
		return {ad.bank, ad.row, ad.col[8:2], 2'(ad.col[1:0] + i)};
	endfunction

	task automatic write_burst(input sdram_addr_t ad, input data_t w [4], output int n_next);
		int idx;
		@(posedge clk_100m);
		wr_req  <= 1'b1;
		addr    <= ad;
		wr_data <= w[0];
		idx     = 1;
		n_next  = 0;
		do begin
			@(posedge clk_100m);
			if (s_wr_next) begin
				n_next++;
				if (idx < 4) begin
					wr_data <= w[idx];
					idx++;
				end
			end
		end while (!s_wr_ack);
		wr_req <= 1'b0;
	endtask

	task automatic read_burst(input sdram_addr_t ad, output data_t r [4], output int n_valid);
		@(posedge clk_100m);
		rd_req  <= 1'b1;
		addr    <= ad;
		n_valid = 0;
		do begin
			@(posedge clk_100m);
			if (s_rd_valid) begin
				if (n_valid < 4)
					r[n_valid] = s_rd_data;
				n_valid++;
			end
		end while (!s_rd_ack);
		rd_req <= 1'b0;
	endtask

	task automatic report_test(input string name, input int errs);
		tests_run++;
		if (errs == 0) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed with %0d errors", name, errs);
			tests_failed++;
		end
	endtask

	//////////////////////////////////////////////////
	// monitor and timeout
	//////////////////////////////////////////////////

	always @(negedge clk_100m) begin
		cyc++;
		s_wr_next   = wr_data_next;
		s_wr_ack    = wr_ack;
		s_rd_ack    = rd_ack;
		s_rd_valid  = rd_valid;
		s_init_done = init_done;
		s_busy      = busy;
		s_rd_data   = rd_data;
		if (!init_done) begin
			if (wr_ack || rd_ack || rd_valid || wr_data_next)
				init_viol++;
			if (pin_cmd != CMD_NOP) begin
				init_cmds.push_back(pin_cmd);
				if (pin_cmd == CMD_MRS)
					mrs_a = pin_a;
			end
		end else begin
			wr_ack_total += wr_ack;
			rd_ack_total += rd_ack;
			valid_total  += rd_valid;
			if (rd_ack && !rd_valid)
				ack_mis++;
			// byte masks stay open while the device is in use
			if ((pin_cmd != CMD_NOP) && (pin_dqm != 2'b00))
				dqm_viol++;
			if (pin_cmd == CMD_REFRESH) begin
				ref_after_init++;
				ref_win = T_RFC - 1;
			end
			if (pin_cmd == CMD_ACTIVE)
				in_access = 1'b1;
			if ((in_access || (ref_win > 0)) && !busy)
				busy_viol++;
			if (wr_ack || rd_ack)
				in_access = 1'b0;
			if (ref_win > 0)
				ref_win--;
		end
		if (cyc >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin
		sdram_addr_t ad;
		sdram_addr_t fixed_ad;
		sdram_cmd_t  exp_seq [4];
		data_t       w [4];
		data_t       fixed_w [4];
		data_t       r [4];
		data_t       exp;
		logic [23:0] key;
		int          n;
		int          n_wr;
		int          n_rd;
		int          frame_err;
		int          t0;
		int          ref0;
		int          gap;
		logic        idle_seen;

		rst_n   = 1'b0;
		wr_req  = 1'b0;
		rd_req  = 1'b0;
		addr    = '0;
		wr_data = '0;
		frame_err = 0;
		repeat (5) @(posedge clk_100m);
		rst_n <= 1'b1;

		// reset and init
		while (!s_init_done)
			@(posedge clk_100m);
		test_err = 0;
		exp_seq = '{CMD_PRECHARGE, CMD_REFRESH, CMD_REFRESH, CMD_MRS};
		if (init_viol != 0) begin
			$display("user outputs were active before init finished");
			test_err++;
		end
		if (init_cmds.size() != 4) begin
			$display("Error reset_init: expected 4 commands, actual %0d", init_cmds.size());
			test_err++;
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (init_cmds[i] != exp_seq[i]) begin
					$display("Error reset_init: expected %h, actual %h", exp_seq[i], init_cmds[i]);
					test_err++;
				end
			end
		end
		if (mrs_a != MODE_WORD) begin
			$display("Error reset_init: expected %h, actual %h", MODE_WORD, mrs_a);
			test_err++;
		end
		report_test("reset_init", test_err);

		// write then read back
		test_err = 0;
		fixed_ad = '{bank: 2'd1, row: 13'd77, col: 9'd8};
		fixed_w  = '{16'ha5a5, 16'h1234, 16'hbeef, 16'h0f0f};
		write_burst(fixed_ad, fixed_w, n);
		if (n != 3) begin
			$display("Error framing: expected 3 word requests, actual %0d", n);
			frame_err++;
		end
		for (int i = 0; i < 4; i++)
			ref_mem[word_addr(fixed_ad, i)] = fixed_w[i];
		read_burst(fixed_ad, r, n);
		if (n != 4) begin
			$display("Error framing: expected 4 valid words, actual %0d", n);
			frame_err++;
		end
		for (int i = 0; i < 4; i++) begin
			if (r[i] != fixed_w[i]) begin
				$display("Error write_read: expected %h, actual %h", fixed_w[i], r[i]);
				test_err++;
			end
		end
		if ((wr_ack_total != 1) || (rd_ack_total != 1)) begin
			$display("write and read did not each give a single ack");
			test_err++;
		end
		report_test("write_read", test_err);

		// random traffic
		test_err = 0;
		n_wr = 1;
		n_rd = 1;
		t0   = cyc;
		ref0 = ref_after_init;
		for (int k = 0; k < N_RANDOM; k++) begin
			ad.bank = 2'(take_bits(2));
			ad.row  = 13'(take_bits(2));
			ad.col  = 9'(take_bits(3));
			if (take_bits(1) == 1) begin
				for (int i = 0; i < 4; i++)
					w[i] = 16'(take_bits(16));
				write_burst(ad, w, n);
				if (n != 3) begin
					$display("Error framing: expected 3 word requests, actual %0d", n);
					frame_err++;
				end
				for (int i = 0; i < 4; i++)
					ref_mem[word_addr(ad, i)] = w[i];
				n_wr++;
			end else begin
				read_burst(ad, r, n);
				if (n != 4) begin
					$display("Error framing: expected 4 valid words, actual %0d", n);
					frame_err++;
				end
				for (int i = 0; i < 4; i++) begin
					key = word_addr(ad, i);
					exp = ref_mem.exists(key) ? ref_mem[key] : 16'h0000;
					if (r[i] != exp) begin
						$display("Error random: expected %h, actual %h", exp, r[i]);
						test_err++;
					end
				end
				n_rd++;
			end
			gap = int'(take_bits(2));
			repeat (gap) @(posedge clk_100m);
		end
		report_test("random", test_err);

		// burst framing and ack counts
		if (wr_ack_total != n_wr) begin
			$display("Error framing: expected %0d write acks, actual %0d", n_wr, wr_ack_total);
			frame_err++;
		end
		if (rd_ack_total != n_rd) begin
			$display("Error framing: expected %0d read acks, actual %0d", n_rd, rd_ack_total);
			frame_err++;
		end
		if (valid_total != 4 * n_rd) begin
			$display("Error framing: expected %0d valid words, actual %0d",
				4 * n_rd, valid_total);
			frame_err++;
		end
		if (ack_mis != 0) begin
			$display("read ack came without its last word %0d times", ack_mis);
			frame_err++;
		end
		if (dqm_viol != 0) begin
			$display("dqm was not low on %0d commands after init", dqm_viol);
			frame_err++;
		end
		report_test("framing", frame_err);

		// refresh
		test_err = 0;
		if (ref_after_init - ref0 < (cyc - t0) / (REF_INTERVAL + LONGEST_ACCESS)) begin
			$display("only %0d refreshes in %0d cycles", ref_after_init - ref0, cyc - t0);
			test_err++;
		end
		if (model_errors != 0) begin
			$display("memory model reported %0d timing errors", model_errors);
			test_err++;
		end
		read_burst(fixed_ad, r, n);
		if (n != 4) begin
			$display("Error refresh: expected 4 valid words, actual %0d", n);
			test_err++;
		end
		for (int i = 0; i < 4; i++) begin
			key = word_addr(fixed_ad, i);
			if (r[i] != ref_mem[key]) begin
				$display("Error refresh: expected %h, actual %h", ref_mem[key], r[i]);
				test_err++;
			end
		end
		report_test("refresh", test_err);

		// busy
		test_err = 0;
		if (busy_viol != 0) begin
			$display("busy was low during an access or refresh %0d times", busy_viol);
			test_err++;
		end
		idle_seen = 1'b0;
		for (int i = 0; (i < 40) && !idle_seen; i++) begin
			@(posedge clk_100m);
			if (!s_busy)
				idle_seen = 1'b1;
		end
		if (!idle_seen) begin
			$display("busy stayed high while idle with no requests");
			test_err++;
		end
		report_test("busy", test_err);

		$display("tests run %0d, failed %0d", tests_run, tests_failed);
		if (tests_failed == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* build.f */
source/sdram_pkg.sv
source/sdram_ctrl.sv
source/sdram_cmd.sv
source/sdram_dq.sv
source/sdram_top.sv
sim/sdram_model.sv
sim/tb_sdram.sv

/* Bender.yml */
package:
  name: sdram_ctrl

sources:
  - source/sdram_pkg.sv
  - source/sdram_ctrl.sv
  - source/sdram_cmd.sv
  - source/sdram_dq.sv
  - source/sdram_top.sv
  - target: simulation
    files:
      - sim/sdram_model.sv
      - sim/tb_sdram.sv
